// ==== data_memory.f ====
verilog/dmem_pkg.sv
verilog/bank_port_if.sv
verilog/access_splitter.sv
verilog/ram_bank.sv
verilog/load_aligner.sv
verilog/data_memory.sv
bench/data_memory_tb.sv

// ==== Makefile ====
# Verilator build and run for the data memory testbench

VERILATOR ?= verilator
TOP       ?= data_memory_tb
FILELIST  ?= data_memory.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/data_memory_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_memory_tb;

    import dmem_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int CREDITS        = 3;
    localparam int MEM_BYTES      = 8 * (2 ** 12);
    localparam int REGION_BASE    = 100;
    localparam int REGION_DWORDS  = 8;
    localparam int PARTIAL_STORES = 24;
    localparam int MIX_REQUESTS   = 64;
    localparam int TOTAL_REQUESTS = 2 + 15 + (REGION_DWORDS + 2 * PARTIAL_STORES) + 28
                                    + MIX_REQUESTS;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 30 * TOTAL_REQUESTS + 200;

    logic          clk;
    logic          arst_n;
    logic          req_valid;
    logic          req_write;
    access_width_e req_width;
    logic [63:0]   req_addr;
    logic [63:0]   req_wdata;
    logic          rsp_valid;
    logic [63:0]   rsp_data;
    logic          credit_return;

    // byte image of the RAM indexed from RAM_BASE
    logic [7:0]  ref_mem [0:MEM_BYTES-1];
    logic [63:0] expected_q [$];

    int          credits = CREDITS;
    int          issued = 0;
    int          returned = 0;
    int          checks = 0;
    int          errors = 0;
    logic [31:0] rng_state = 32'd62;

    data_memory dut0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_width     (req_width),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .credit_return (credit_return)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [63:0] random_dword();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi, lo};
    endfunction

    function automatic access_width_e random_width(input int span);
        case (int'(next_random() % 32'(span)))
            0:       return W8;
            1:       return W16;
            2:       return W32;
            default: return W64;
        endcase
    endfunction

    function automatic int width_bytes(input access_width_e width);
        case (width)
            W8:      return 1;
            W16:     return 2;
            W32:     return 4;
            default: return 8;
        endcase
    endfunction

    function automatic logic [63:0] dword_addr(input int idx, input int off);
        return RAM_BASE + 64'(idx) * 64'd8 + 64'(off);
    endfunction

    // first byte of the access rounded down to its natural alignment
    function automatic int model_base(input logic [63:0] addr, input access_width_e width);
        logic [63:0] rel;
        rel = addr - RAM_BASE;
        return int'(rel[31:0]) & ~(width_bytes(width) - 1);
    endfunction

    task automatic model_store(input logic [63:0] addr, input access_width_e width,
                               input logic [63:0] data);
        int base;
        base = model_base(addr, width);
        for (int i = 0; i < width_bytes(width); i++) begin
            ref_mem[base + i] = data[8*i +: 8];
        end
    endtask

    function automatic logic [63:0] model_load(input logic [63:0] addr,
                                               input access_width_e width);
        logic [63:0] value;
        int          base;
        value = 64'h0;
        base  = model_base(addr, width);
        for (int i = 0; i < width_bytes(width); i++) begin
            value[8*i +: 8] = ref_mem[base + i];
        end
        return value;
    endfunction

    task automatic check_data(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // issues one request and stalls while no credit is left
    task automatic issue(input logic is_write, input access_width_e width,
                         input logic [63:0] addr, input logic [63:0] wdata);
        @(posedge clk);
        while (credits == 0) begin
            req_valid <= 1'b0;
            @(posedge clk);
        end
        req_valid <= 1'b1;
        req_write <= is_write;
        req_width <= width;
        req_addr  <= addr;
        req_wdata <= wdata;
        credits--;
        issued++;
        if (is_write) begin
            model_store(addr, width, wdata);
        end else begin
            expected_q.push_back(model_load(addr, width));
        end
    endtask

    // stop issuing and wait for every credit to come home
    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        req_valid <= 1'b0;
        while (credits != CREDITS && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (credits != CREDITS) begin
            errors++;
            $display("at %0t ns the credits did not return after the pipeline drained", $time);
        end
        check_count("credits", credits, CREDITS);
        check_count("pending loads", expected_q.size(), 0);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            if (credit_return) begin
                credits++;
                returned++;
                if (credits > CREDITS) begin
                    errors++;
                    $display("at %0t ns more credits came back than were spent", $time);
                end
            end
            if (rsp_valid) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("at %0t ns a load response arrived with no load pending", $time);
                end else begin
                    check_data("rsp_data", rsp_data, expected_q.pop_front());
                end
            end
        end
    end

    task automatic test_latency_and_reset();
        int   cycles;
        logic seen;
        $display("test: reset state and load latency");
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_bit("rsp_valid", rsp_valid, 1'b0);
            check_bit("credit_return", credit_return, 1'b0);
        end
        @(posedge clk);
        arst_n <= 1'b1;
        issue(1'b1, W64, dword_addr(0, 0), random_dword());
        drain();
        issue(1'b0, W64, dword_addr(0, 0), 64'h0);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 10) begin
            @(posedge clk);
            req_valid <= 1'b0;
            cycles++;
            @(negedge clk);
            seen = rsp_valid;
        end
        check_count("load latency in edges", cycles, 3);
        check_bit("credit_return", credit_return, 1'b1);
        drain();
    endtask

    task automatic test_field_extraction();
        $display("test: width and offset extraction");
        issue(1'b1, W64, dword_addr(10, 0), 64'hfedc_ba98_7654_3210);
        for (int off = 0; off < 8; off++) begin
            issue(1'b0, W8, dword_addr(10, off), 64'h0);
        end
        for (int off = 0; off < 8; off += 2) begin
            issue(1'b0, W16, dword_addr(10, off), 64'h0);
        end
        issue(1'b0, W32, dword_addr(10, 0), 64'h0);
        issue(1'b0, W32, dword_addr(10, 4), 64'h0);
        drain();
    endtask

    task automatic test_partial_stores();
        int            idx;
        int            off;
        access_width_e width;
        $display("test: partial stores");
        for (int i = 0; i < REGION_DWORDS; i++) begin
            issue(1'b1, W64, dword_addr(REGION_BASE + i, 0), random_dword());
        end
        for (int i = 0; i < PARTIAL_STORES; i++) begin
            idx   = REGION_BASE + int'(next_random() % 32'd8);
            width = random_width(3);
            // offset kept on the natural alignment here
            off   = int'(next_random() % 32'd8) & ~(width_bytes(width) - 1);
            issue(1'b1, width, dword_addr(idx, off), random_dword());
            issue(1'b0, W64, dword_addr(idx, 0), 64'h0);
        end
        drain();
    endtask

    task automatic test_alignment_rule();
        $display("test: alignment rule");
        issue(1'b1, W64, dword_addr(200, 0), 64'h8877_6655_4433_2211);
        for (int off = 0; off < 8; off++) begin
            issue(1'b0, W16, dword_addr(200, off), 64'h0);
            issue(1'b0, W32, dword_addr(200, off), 64'h0);
            issue(1'b0, W64, dword_addr(200, off), 64'h0);
        end
        // lands on bytes 4..7 and 2..3
        issue(1'b1, W32, dword_addr(200, 5), 64'h0000_0000_dead_beef);
        issue(1'b1, W16, dword_addr(200, 3), 64'h0000_0000_0000_a5c3);
        issue(1'b0, W64, dword_addr(200, 0), 64'h0);
        drain();
    endtask

    task automatic test_credit_flow();
        logic [31:0]   pick;
        int            idx;
        int            off;
        access_width_e width;
        $display("test: credit flow");
        for (int i = 0; i < MIX_REQUESTS; i++) begin
            pick  = next_random();
            idx   = REGION_BASE + int'(next_random() % 32'd8);
            off   = int'(next_random() % 32'd8);
            width = random_width(4);
            issue(pick[0], width, dword_addr(idx, off), random_dword());
        end
        drain();
        check_count("credits returned", returned, issued);
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_width = W8;
        req_addr  = 64'h0;
        req_wdata = 64'h0;

        test_latency_and_reset();
        test_field_extraction();
        test_partial_stores();
        test_alignment_rule();
        test_credit_flow();

        $display("checks %0d, errors %0d, requests %0d, credits returned %0d",
                 checks, errors, issued, returned);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // bounded by the request count of all tests
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles with %0d requests issued",
                 WATCHDOG_CYCLES, issued);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/data_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_memory #(
    parameter int WORD_ADDR_W = 12
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req_valid,
    input  logic                    req_write,
    input  dmem_pkg::access_width_e req_width,
    input  logic [63:0]             req_addr,
    input  logic [63:0]             req_wdata,
    output logic                    rsp_valid,
    output logic [63:0]             rsp_data,
    output logic                    credit_return
);

    import dmem_pkg::*;

    load_meta_t req_meta;

    // bytes 0-3 and 4-7 of each doubleword
    bank_port_if #(.WORD_ADDR_W(WORD_ADDR_W)) even_port ();
    bank_port_if #(.WORD_ADDR_W(WORD_ADDR_W)) odd_port ();

    access_splitter #(
        .WORD_ADDR_W (WORD_ADDR_W)
    ) splitter (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_width (req_width),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .even_port (even_port.source),
        .odd_port  (odd_port.source),
        .req_meta  (req_meta)
    );

    ram_bank #(
        .WORD_ADDR_W (WORD_ADDR_W)
    ) even_bank (
        .clk  (clk),
        .port (even_port.bank)
    );

    ram_bank #(
        .WORD_ADDR_W (WORD_ADDR_W)
    ) odd_bank (
        .clk  (clk),
        .port (odd_port.bank)
    );

    load_aligner aligner (
        .clk           (clk),
        .arst_n        (arst_n),
        .even_port     (even_port.sink),
        .odd_port      (odd_port.sink),
        .req_meta      (req_meta),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .credit_return (credit_return)
    );

endmodule

`default_nettype wire

// ==== verilog/load_aligner.sv ====
`timescale 1ns/1ns
`default_nettype none

module load_aligner (
    input  logic                 clk,
    input  logic                 arst_n,
    bank_port_if.sink            even_port,
    bank_port_if.sink            odd_port,
    input  dmem_pkg::load_meta_t req_meta,
    output logic                 rsp_valid,
    output logic [63:0]          rsp_data,
    output logic                 credit_return
);

    import dmem_pkg::*;

    load_meta_t  meta_q;
    logic [63:0] dword;
    logic [63:0] shifted;
    logic [63:0] field;

    // meta follows the bank access by one stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            meta_q <= '0;
        end else begin
            meta_q <= req_meta;
        end
    end

    // odd bank carries the upper four bytes
    assign dword = {odd_port.rdata, even_port.rdata};

    // addressed field down to bit 0
    assign shifted = dword >> {meta_q.offset, 3'b000};

    // zero extension
    always_comb begin
        case (meta_q.width)
            W8:      field = {56'h0, shifted[7:0]};
            W16:     field = {48'h0, shifted[15:0]};
            W32:     field = {32'h0, shifted[31:0]};
            default: field = shifted;
        endcase
    end

    // every retired slot hands a credit back, loads also respond
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid     <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            rsp_valid     <= meta_q.valid && meta_q.is_load;
            credit_return <= meta_q.valid;
        end
    end

    // result data only moves on a load
    always_ff @(posedge clk) begin
        if (meta_q.valid && meta_q.is_load) begin
            rsp_data <= field;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ram_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module ram_bank #(
    parameter int WORD_ADDR_W = 12
) (
    input  logic     clk,
    bank_port_if.bank port
);

    localparam int DEPTH = 2 ** WORD_ADDR_W;

    // one 32-bit word per doubleword index
    logic [31:0] mem [DEPTH];

    // byte-lane write, registered read
    // rdata keeps the last read word while the bank is idle or writing
    always_ff @(posedge clk) begin
        if (port.en) begin
            if (port.we) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (port.be[lane]) begin
                        mem[port.addr][lane*8 +: 8] <= port.wdata[lane*8 +: 8];
                    end
                end
            end else begin
                port.rdata <= mem[port.addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/access_splitter.sv ====
`timescale 1ns/1ns
`default_nettype none

module access_splitter #(
    parameter int WORD_ADDR_W = 12
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req_valid,
    input  logic                    req_write,
    input  dmem_pkg::access_width_e req_width,
    input  logic [63:0]             req_addr,
    input  logic [63:0]             req_wdata,
    bank_port_if.source             even_port,
    bank_port_if.source             odd_port,
    output dmem_pkg::load_meta_t    req_meta
);

    import dmem_pkg::*;

    logic [63:0]            rel_addr;
    logic [WORD_ADDR_W-1:0] word_idx;
    logic [2:0]             offset;
    logic [7:0]             base_mask;
    logic [7:0]             byte_mask;
    logic [63:0]            lane_wdata;
    logic                   even_en;
    logic                   odd_en;

    // byte address relative to the start of RAM
    assign rel_addr = req_addr - RAM_BASE;

    // both banks share the doubleword index
    assign word_idx = rel_addr[WORD_ADDR_W+2:3];

    // drop offset bits below the access width, set the lane count
    always_comb begin
        case (req_width)
            W8: begin
                base_mask = 8'h01;
                offset    = rel_addr[2:0];
            end
            W16: begin
                base_mask = 8'h03;
                offset    = {rel_addr[2:1], 1'b0};
            end
            W32: begin
                base_mask = 8'h0f;
                offset    = {rel_addr[2], 2'b00};
            end
            default: begin
                base_mask = 8'hff;
                offset    = 3'b000;
            end
        endcase
    end

    // aligned offset keeps the mask inside the doubleword
    assign byte_mask = base_mask << offset;

    // move store data onto its byte lanes
    assign lane_wdata = req_wdata << {offset, 3'b000};

    // a store only touches the bank holding some of its bytes
    assign even_en = req_valid && (!req_write || (byte_mask[3:0] != 4'h0));
    assign odd_en  = req_valid && (!req_write || (byte_mask[7:4] != 4'h0));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            even_port.en <= 1'b0;
            even_port.we <= 1'b0;
            odd_port.en  <= 1'b0;
            odd_port.we  <= 1'b0;
            req_meta     <= '0;
        end else begin
            even_port.en     <= even_en;
            even_port.we     <= req_valid && req_write;
            odd_port.en      <= odd_en;
            odd_port.we      <= req_valid && req_write;
            req_meta.valid   <= req_valid;
            req_meta.is_load <= req_valid && !req_write;
            req_meta.width   <= req_width;
            req_meta.offset  <= offset;
        end
    end

    // address and data lanes
    always_ff @(posedge clk) begin
        even_port.addr  <= word_idx;
        even_port.wdata <= lane_wdata[31:0];
        even_port.be    <= byte_mask[3:0];
        odd_port.addr   <= word_idx;
        odd_port.wdata  <= lane_wdata[63:32];
        odd_port.be     <= byte_mask[7:4];
    end

endmodule

`default_nettype wire

// ==== verilog/bank_port_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface bank_port_if #(
    parameter int WORD_ADDR_W = 12
);

    // request side, registered in the splitter
    logic                   en;
    logic                   we;
    logic [WORD_ADDR_W-1:0] addr;
    logic [31:0]            wdata;
    logic [3:0]             be;

    // read data, registered in the bank
    logic [31:0]            rdata;

    modport source (
        output en,
        output we,
        output addr,
        output wdata,
        output be
    );

    modport bank (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        input  be,
        output rdata
    );

    modport sink (
        input  rdata
    );

endinterface

`default_nettype wire

// ==== verilog/dmem_pkg.sv ====
`default_nettype none

package dmem_pkg;

    // access size as seen by the load/store unit
    // the encoding follows funct3[1:0] of the RISC-V load and store opcodes
    typedef enum logic [1:0] {
        W8  = 2'd0,
        W16 = 2'd1,
        W32 = 2'd2,
        W64 = 2'd3
    } access_width_e;

    // per-request bookkeeping carried from the splitter to the aligner
    // valid marks an occupied pipeline slot, store or load
    // offset is already rounded down to the natural alignment of width
    typedef struct packed {
        logic          valid;
        logic          is_load;
        access_width_e width;
        logic [2:0]    offset;
    } load_meta_t;

    // first byte address decoded by the data RAM
    // requests are expected to stay above this base
    localparam logic [63:0] RAM_BASE = 64'h0000_0000_8000_0000;

endpackage

`default_nettype wire
